// File: sources.f
+incdir+src
+incdir+verification
src/fetch_pkg.sv
src/pc_gen.sv
src/axi_read_master.sv
src/axi_rom_slave.sv
src/if_stage.sv
src/fetch_top.sv
verification/fetch_tb.sv

// File: verification/fetch_tb_stim.svh
`ifndef FETCH_TB_STIM_SVH
`define FETCH_TB_STIM_SVH

// program image, lower half at the lower pc of each 8-byte word
localparam int PROG_WORDS = 8;

logic [63:0] prog_tbl [PROG_WORDS] = '{
  64'h00200113_00100093,
  64'h40208233_002081b3,
  64'h0020e333_0020f2b3,
  64'h00209433_0020c3b3,
  64'h0011a023_00012483,
  64'h02208533_fff00593,
  64'h0220c633_0220d6b3,
  64'h00100073_00000073
};

// stall per cycle: none, held high, or random stretches
typedef enum logic [1:0] {
  STALL_OFF,
  STALL_ON,
  STALL_RAND
} stall_mode_t;

// redirect pulses on the first cycle of a row only
typedef struct packed {
  int unsigned cycles;
  stall_mode_t stall_mode;
  logic        redir;
  pc_t         target;
} ctrl_row_t;

localparam int CTRL_ROWS = 12;

// targets keep every delivery inside the program or past the memory end
ctrl_row_t ctrl_tbl [CTRL_ROWS] = '{
  '{32, STALL_OFF,  1'b0, 64'h0},
  '{24, STALL_OFF,  1'b1, 64'h20},
  '{36, STALL_RAND, 1'b1, 64'h8},
  '{10, STALL_ON,   1'b0, 64'h0},
  '{18, STALL_OFF,  1'b0, 64'h0},
  '{20, STALL_OFF,  1'b1, 64'h1000},
  '{24, STALL_OFF,  1'b1, 64'h4},
  '{36, STALL_RAND, 1'b1, 64'h18},
  '{8,  STALL_ON,   1'b1, 64'h34},
  '{12, STALL_OFF,  1'b0, 64'h0},
  '{30, STALL_RAND, 1'b1, 64'h2000},
  '{30, STALL_OFF,  1'b1, 64'h0}
};

`endif

// File: verification/fetch_tb.sv
`include "fetch_params.svh"

module fetch_tb
  import fetch_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  // one fetch round trip, idle, ar, latency, r beat
  localparam int SEQ_GAP = 1 + 1 + `FETCH_RD_LAT + 1;

  `include "fetch_tb_stim.svh"

  logic                                clk = 1'b0;
  logic                                rst_n;
  logic                                ld_we_i;
  logic [$clog2(`FETCH_MEM_WORDS)-1:0] ld_addr_i;
  logic [63:0]                         ld_data_i;
  logic                                redirect_i;
  pc_t                                 redirect_pc_i;
  logic                                stall_i;
  inst_t                               inst_o;
  pc_t                                 inst_pc_o;
  logic                                inst_valid_o;
  logic                                fetch_err_o;

  // reference model and bookkeeping
  logic running = 1'b0;
  logic dirty = 1'b0;
  logic prev_stall = 1'b0;
  pc_t  exp_pc = `FETCH_RESET_PC;
  int   cyc = 0;
  int   last_evt_cyc = 0;
  int   n_inst = 0;
  int   n_buserr = 0;
  int   val_errs = 0;
  int   oth_errs = 0;

  fetch_top i_fetch_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .ld_we_i       (ld_we_i),
    .ld_addr_i     (ld_addr_i),
    .ld_data_i     (ld_data_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .stall_i       (stall_i),
    .inst_o        (inst_o),
    .inst_pc_o     (inst_pc_o),
    .inst_valid_o  (inst_valid_o),
    .fetch_err_o   (fetch_err_o)
  );

  always #10 clk = ~clk;

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    assert (got === exp) else begin
      val_errs++;
      $display("Error: %s = %h, expected %h", name, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    oth_errs++;
    $display("Error: %s", what);
  endtask

  function automatic logic in_program(input pc_t pc);
    return (pc >> 3) < PROG_WORDS;
  endfunction

  function automatic logic beyond_memory(input pc_t pc);
    return (pc >> 3) >= `FETCH_MEM_WORDS;
  endfunction

  // bit 2 picks the half of the program word
  function automatic inst_t prog_word_at(input pc_t pc);
    logic [63:0] w;
    w = prog_tbl[pc >> 3];
    return pc[2] ? w[63:32] : w[31:0];
  endfunction

  // sampled mid cycle, inputs and outputs both settled
  always @(negedge clk) begin
    if (!rst_n) begin
      compare_value("inst_valid_o", inst_valid_o, 1'b0);
      compare_value("fetch_err_o", fetch_err_o, 1'b0);
      compare_value("inst_o", inst_o, `FETCH_NOP);
      compare_value("inst_pc_o", inst_pc_o, `FETCH_RESET_PC);
    end else if (running) begin
      // nop fill
      if (!inst_valid_o) begin
        compare_value("inst_o", inst_o, `FETCH_NOP);
      end
      assert (!(inst_valid_o && fetch_err_o))
        else report_failure("inst_valid_o and fetch_err_o high in the same cycle");
      if (inst_valid_o || fetch_err_o) begin
        // the r beat one cycle back needs r_ready, so no stall there
        assert (!prev_stall) else report_failure("result delivered after a stalled cycle");
        if (!dirty) begin
          assert (cyc - last_evt_cyc == SEQ_GAP)
            else report_failure("sequential delivery gap is not 1+1+RD_LAT+1 cycles");
        end
        compare_value("inst_pc_o", inst_pc_o, exp_pc);
        if (inst_valid_o) begin
          assert (in_program(exp_pc))
            else report_failure("instruction delivered outside the loaded program");
          if (in_program(exp_pc)) begin
            compare_value("inst_o", inst_o, prog_word_at(exp_pc));
          end
          n_inst++;
        end else begin
          assert (beyond_memory(exp_pc))
            else report_failure("bus error reported for an address inside memory");
          n_buserr++;
        end
        exp_pc       = exp_pc + 64'd4;
        last_evt_cyc = cyc;
        dirty        = stall_i | redirect_i;
      end else begin
        dirty = dirty | stall_i | redirect_i;
      end
      // a delivery seen with the pulse is still old path
      if (redirect_i) begin
        exp_pc = redirect_pc_i;
      end
      prev_stall = stall_i;
      cyc++;
    end
  end

  initial begin : stimulus
    int unsigned stretch_left;
    logic        stall_lvl;
    stretch_left = 0;
    stall_lvl    = 1'b0;
    void'($urandom(32'h6d81));
    rst_n         = 1'b0;
    ld_we_i       = 1'b0;
    ld_addr_i     = '0;
    ld_data_i     = '0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    stall_i       = 1'b0;
    // program load, one word per cycle under reset
    for (int i = 0; i < PROG_WORDS; i++) begin
      @(posedge clk);
      ld_we_i   <= 1'b1;
      ld_addr_i <= i[$clog2(`FETCH_MEM_WORDS)-1:0];
      ld_data_i <= prog_tbl[i];
    end
    @(posedge clk);
    ld_we_i <= 1'b0;
    rst_n   <= 1'b1;
    running = 1'b1;
    for (int r = 0; r < CTRL_ROWS; r++) begin
      for (int unsigned k = 0; k < ctrl_tbl[r].cycles; k++) begin
        case (ctrl_tbl[r].stall_mode)
          STALL_ON: stall_i <= 1'b1;
          STALL_RAND: begin
            // flip level after a random run of 1 to 5 cycles
            if (stretch_left == 0) begin
              stall_lvl    = ~stall_lvl;
              stretch_left = 1 + ($urandom % 5);
            end
            stretch_left--;
            stall_i <= stall_lvl;
          end
          default: stall_i <= 1'b0;
        endcase
        redirect_i    <= ctrl_tbl[r].redir && (k == 0);
        redirect_pc_i <= ctrl_tbl[r].target;
        @(posedge clk);
      end
    end
    running = 1'b0;
    stall_i    <= 1'b0;
    redirect_i <= 1'b0;
    assert (n_inst > 0) else report_failure("no instruction was delivered");
    assert (n_buserr > 0) else report_failure("no bus error was reported");
    $display("summary: %0d value errors, %0d other errors, %0d instructions, %0d bus errors",
             val_errs, oth_errs, n_inst, n_buserr);
    if (val_errs == 0 && oth_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // limit from table length, generous per cycle, plus reset
  initial begin : watchdog
    longint unsigned total_cyc;
    longint unsigned limit_ns;
    total_cyc = 0;
    for (int r = 0; r < CTRL_ROWS; r++) begin
      total_cyc += ctrl_tbl[r].cycles;
    end
    limit_ns = total_cyc * (`FETCH_RD_LAT + 4) * 20 + (PROG_WORDS + 2) * 20;
    #(limit_ns);
    $display("Error: watchdog expired before the stimulus table finished");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: src/fetch_top.sv
`include "fetch_params.svh"

module fetch_top
  import fetch_pkg::*;
(
  input  logic                                clk,
  input  logic                                rst_n,
  // program load
  input  logic                                ld_we_i,
  input  logic [$clog2(`FETCH_MEM_WORDS)-1:0] ld_addr_i,
  input  logic [63:0]                         ld_data_i,
  // decode control
  input  logic                                redirect_i,
  input  pc_t                                 redirect_pc_i,
  input  logic                                stall_i,
  // to decode
  output inst_t                               inst_o,
  output pc_t                                 inst_pc_o,
  output logic                                inst_valid_o,
  output logic                                fetch_err_o
);

  // ar and r channel wires
  logic        ar_valid;
  logic        ar_ready;
  pc_t         ar_addr;
  logic        r_valid;
  logic        r_ready;
  logic [63:0] r_data;
  rd_resp_t    r_resp;

  if_stage u_if_stage (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .stall_i       (stall_i),
    .ar_valid_o    (ar_valid),
    .ar_ready_i    (ar_ready),
    .ar_addr_o     (ar_addr),
    .r_valid_i     (r_valid),
    .r_ready_o     (r_ready),
    .r_data_i      (r_data),
    .r_resp_i      (r_resp),
    .inst_o        (inst_o),
    .inst_pc_o     (inst_pc_o),
    .inst_valid_o  (inst_valid_o),
    .fetch_err_o   (fetch_err_o)
  );

  // single beat reads, so r_last is left open
  axi_rom_slave u_axi_rom_slave (
    .clk        (clk),
    .rst_n      (rst_n),
    .ld_we_i    (ld_we_i),
    .ld_addr_i  (ld_addr_i),
    .ld_data_i  (ld_data_i),
    .ar_valid_i (ar_valid),
    .ar_ready_o (ar_ready),
    .ar_addr_i  (ar_addr),
    .r_valid_o  (r_valid),
    .r_ready_i  (r_ready),
    .r_data_o   (r_data),
    .r_resp_o   (r_resp),
    .r_last_o   ()
  );

endmodule

// File: src/if_stage.sv
`include "fetch_params.svh"

module if_stage
  import fetch_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  // decode control
  input  logic        redirect_i,
  input  pc_t         redirect_pc_i,
  input  logic        stall_i,
  // ar channel
  output logic        ar_valid_o,
  input  logic        ar_ready_i,
  output pc_t         ar_addr_o,
  // r channel
  input  logic        r_valid_i,
  output logic        r_ready_o,
  input  logic [63:0] r_data_i,
  input  rd_resp_t    r_resp_i,
  // to decode
  output inst_t       inst_o,
  output pc_t         inst_pc_o,
  output logic        inst_valid_o,
  output logic        fetch_err_o
);

  pc_t   pc;
  logic  fetch_en;
  logic  rd_done;
  logic  rd_drop;
  logic  rd_err;
  inst_t rd_word;
  logic  rd_keep;
  inst_t inst_q;
  pc_t   inst_pc_q;
  logic  inst_valid_q;
  logic  fetch_err_q;

  // no new read while decode is busy or the path changes
  assign fetch_en = ~stall_i & ~redirect_i;
  // result that belongs to the current path
  assign rd_keep  = rd_done & ~rd_drop;

  pc_gen u_pc_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .advance_i     (rd_keep),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .pc_o          (pc)
  );

  axi_read_master u_axi_read_master (
    .clk        (clk),
    .rst_n      (rst_n),
    .fetch_en_i (fetch_en),
    .addr_i     (pc),
    .redirect_i (redirect_i),
    .stall_i    (stall_i),
    .ar_valid_o (ar_valid_o),
    .ar_ready_i (ar_ready_i),
    .ar_addr_o  (ar_addr_o),
    .r_valid_i  (r_valid_i),
    .r_ready_o  (r_ready_o),
    .r_data_i   (r_data_i),
    .r_resp_i   (r_resp_i),
    .done_o     (rd_done),
    .drop_o     (rd_drop),
    .err_o      (rd_err),
    .word_o     (rd_word)
  );

  // decode outputs, one cycle after the r beat
  // nop fill on every cycle without a good instruction
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inst_q       <= `FETCH_NOP;
      inst_pc_q    <= `FETCH_RESET_PC;
      inst_valid_q <= 1'b0;
      fetch_err_q  <= 1'b0;
    end else begin
      inst_valid_q <= rd_keep & ~rd_err;
      fetch_err_q  <= rd_keep & rd_err;
      inst_q       <= (rd_keep & ~rd_err) ? rd_word : `FETCH_NOP;
      // ar_addr still holds the address of the beat just taken
      if (rd_keep) begin
        inst_pc_q <= ar_addr_o;
      end
    end
  end

  assign inst_o       = inst_q;
  assign inst_pc_o    = inst_pc_q;
  assign inst_valid_o = inst_valid_q;
  assign fetch_err_o  = fetch_err_q;

endmodule

// File: src/axi_rom_slave.sv
`include "fetch_params.svh"

module axi_rom_slave
  import fetch_pkg::*;
#(
  parameter int MEM_WORDS = `FETCH_MEM_WORDS,
  parameter int RD_LAT    = `FETCH_RD_LAT
) (
  input  logic                         clk,
  input  logic                         rst_n,
  // program load port, word index
  input  logic                         ld_we_i,
  input  logic [$clog2(MEM_WORDS)-1:0] ld_addr_i,
  input  logic [63:0]                  ld_data_i,
  // ar channel
  input  logic                         ar_valid_i,
  output logic                         ar_ready_o,
  input  pc_t                          ar_addr_i,
  // r channel
  output logic                         r_valid_o,
  input  logic                         r_ready_i,
  output logic [63:0]                  r_data_o,
  output rd_resp_t                     r_resp_o,
  output logic                         r_last_o
);

  localparam int AW = $clog2(MEM_WORDS);
  localparam int CW = $clog2(RD_LAT + 1);

  logic [63:0]   mem [MEM_WORDS];
  logic          busy_q;
  logic [CW-1:0] cnt_q;
  logic          r_valid_q;
  logic [AW-1:0] idx_q;
  logic          oor_q;
  logic [63:0]   r_data_q;
  rd_resp_t      r_resp_q;
  logic          ar_fire;
  logic          r_fire;
  logic          ar_oor;
  logic          expire;

  // accept only with nothing counting and nothing presented
  assign ar_ready_o = ~busy_q & ~r_valid_q;
  assign ar_fire    = ar_valid_i & ar_ready_o;
  assign r_fire     = r_valid_q & r_ready_i;
  // word index past the array end
  assign ar_oor     = (ar_addr_i >> 3) >= pc_t'(MEM_WORDS);
  assign expire     = busy_q & (cnt_q == CW'(1));

  always_ff @(posedge clk) begin
    if (ld_we_i) begin
      mem[ld_addr_i] <= ld_data_i;
    end
  end

  // request capture at the ar handshake
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      idx_q <= ar_addr_i[AW+2:3];
      oor_q <= ar_oor;
    end
  end

  // latency counter, r_valid set RD_LAT edges after capture
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q    <= 1'b0;
      cnt_q     <= '0;
      r_valid_q <= 1'b0;
    end else begin
      if (ar_fire) begin
        busy_q <= 1'b1;
        cnt_q  <= CW'(RD_LAT);
      end else if (expire) begin
        busy_q    <= 1'b0;
        cnt_q     <= '0;
        r_valid_q <= 1'b1;
      end else if (busy_q) begin
        cnt_q <= cnt_q - CW'(1);
      end
      // held until the master takes it
      if (r_fire) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  // response word, zero data on slverr
  always_ff @(posedge clk) begin
    if (expire) begin
      r_data_q <= oor_q ? '0 : mem[idx_q];
      r_resp_q <= oor_q ? RESP_SLVERR : RESP_OKAY;
    end
  end

  assign r_valid_o = r_valid_q;
  assign r_data_o  = r_data_q;
  assign r_resp_o  = r_resp_q;
  // single beat reads only
  assign r_last_o  = 1'b1;

endmodule

// File: src/axi_read_master.sv
module axi_read_master
  import fetch_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  // request side
  input  logic        fetch_en_i,
  input  pc_t         addr_i,
  input  logic        redirect_i,
  input  logic        stall_i,
  // ar channel
  output logic        ar_valid_o,
  input  logic        ar_ready_i,
  output pc_t         ar_addr_o,
  // r channel
  input  logic        r_valid_i,
  output logic        r_ready_o,
  input  logic [63:0] r_data_i,
  input  rd_resp_t    r_resp_i,
  // result side, all valid with done_o
  output logic        done_o,
  output logic        drop_o,
  output logic        err_o,
  output inst_t       word_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_DATA
  } state_t;

  state_t state_q;
  state_t state_d;
  logic   drop_q;
  logic   drop_d;
  pc_t    addr_q;
  logic   ar_fire;
  logic   r_fire;

  // handshakes
  assign ar_fire = ar_valid_o & ar_ready_i;
  assign r_fire  = r_valid_i & r_ready_o;

  // one read in flight at most
  always_comb begin
    state_d = state_q;
    drop_d  = drop_q;
    case (state_q)
      ST_IDLE: begin
        if (fetch_en_i) begin
          state_d = ST_ADDR;
        end
      end
      ST_ADDR: begin
        // ar stays up even if overtaken, the bus must see it through
        if (ar_fire) begin
          state_d = ST_DATA;
        end
        if (redirect_i) begin
          drop_d = 1'b1;
        end
      end
      ST_DATA: begin
        if (redirect_i) begin
          drop_d = 1'b1;
        end
        // drop mark ends with the beat it belongs to
        if (r_fire) begin
          state_d = ST_IDLE;
          drop_d  = 1'b0;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      drop_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      drop_q  <= drop_d;
    end
  end

  // address taken at issue, held until the next issue
  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE && fetch_en_i) begin
      addr_q <= addr_i;
    end
  end

  assign ar_valid_o = (state_q == ST_ADDR);
  assign ar_addr_o  = addr_q;
  // decode stall back-pressures the slave directly
  assign r_ready_o  = (state_q == ST_DATA) & ~stall_i;

  // result of the beat
  // a redirect in the same cycle as the beat also drops it
  assign done_o = r_fire;
  assign drop_o = r_fire & (drop_q | redirect_i);
  assign err_o  = r_fire & (r_resp_i == RESP_SLVERR);
  // bit 2 picks the half of the 8-byte word
  assign word_o = addr_q[2] ? r_data_i[63:32] : r_data_i[31:0];

endmodule

// File: src/pc_gen.sv
`include "fetch_params.svh"

module pc_gen
  import fetch_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  // one pulse per accepted, non-dropped read result
  input  logic advance_i,
  // jump or branch from decode
  input  logic redirect_i,
  input  pc_t  redirect_pc_i,
  // address of the next read to issue
  output pc_t  pc_o
);

  // sequential step is one instruction word in bytes
  localparam pc_t PC_STEP = pc_t'(`FETCH_ILEN / 8);

  pc_t pc_q;
  pc_t pc_d;

  // next pc select
  // redirect wins over advance, a result seen with the
  // redirect pulse belongs to the old path anyway
  always_comb begin
    pc_d = pc_q;
    if (redirect_i) begin
      pc_d = redirect_pc_i;
    end else if (advance_i) begin
      pc_d = pc_q + PC_STEP;
    end
  end

  // pc register
  // holds while stalled, since no result is accepted then
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= `FETCH_RESET_PC;
    end else begin
      pc_q <= pc_d;
    end
  end

  assign pc_o = pc_q;

endmodule

// File: src/fetch_pkg.sv
`include "fetch_params.svh"

package fetch_pkg;

  // fetch address and ar_addr
  typedef logic [`FETCH_XLEN-1:0] pc_t;

  // one instruction word as handed to decode
  typedef logic [`FETCH_ILEN-1:0] inst_t;

  // read response code on the r channel
  // exokay and decerr are never produced here
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2
  } rd_resp_t;

endpackage

// File: src/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// pc and bus address width, RV64
`define FETCH_XLEN 64

// instruction word width
`define FETCH_ILEN 32

// first fetch address out of reset
`define FETCH_RESET_PC 64'h0

// addi x0,x0,0, shown to decode when nothing is delivered
`define FETCH_NOP 32'h00000013

// default rom depth in 64-bit words
`define FETCH_MEM_WORDS 256

// default cycles from ar handshake to r_valid
`define FETCH_RD_LAT 3

`endif
